//--- rtl/pixel_pkg.sv
package pixel_pkg;

    // raster position words
    typedef logic [10:0] h_count_t;
    typedef logic [9:0]  v_count_t;

    // timing that travels alongside every pixel
    typedef struct packed {
        h_count_t h;
        v_count_t v;
        logic     active;
        logic     h_sync;
        logic     v_sync;
        logic     new_frame;
    } timing_t;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb_t;

    typedef struct packed {
        logic [7:0] y;
        logic [7:0] cr;
        logic [7:0] cb;
    } ycc_t;

    // codes 011 and 111 are invalid and select zero
    typedef enum logic [2:0] {
        CHAN_GREEN = 3'b000,
        CHAN_RED   = 3'b001,
        CHAN_BLUE  = 3'b010,
        CHAN_Y     = 3'b100,
        CHAN_CR    = 3'b101,
        CHAN_CB    = 3'b110
    } chan_sel_e;

    typedef enum logic [1:0] {
        BG_CAMERA    = 2'b00,
        BG_GRAY      = 2'b01,
        BG_MASK      = 2'b10,
        BG_Y_MAGENTA = 2'b11
    } bg_sel_e;

    // the sprite target draws nothing in this build
    typedef enum logic [1:0] {
        TGT_NONE      = 2'b00,
        TGT_CROSSHAIR = 2'b01,
        TGT_SPRITE    = 2'b10,
        TGT_NONE_ALT  = 2'b11
    } tgt_sel_e;

    // conversion weights, scaled by 256
    localparam int COEF_Y_R  = 77;
    localparam int COEF_Y_G  = 150;
    localparam int COEF_Y_B  = 29;
    localparam int COEF_CB_R = -43;
    localparam int COEF_CB_G = -85;
    localparam int COEF_CB_B = 128;
    localparam int COEF_CR_R = 128;
    localparam int COEF_CR_G = -107;
    localparam int COEF_CR_B = -21;

    localparam int CONVERT_LATENCY = 3;

endpackage

//--- rtl/video_timing.sv
`timescale 1ns/1ps

module video_timing #(
    parameter int H_ACTIVE     = 1280,
    parameter int H_TOTAL      = 1650,
    parameter int H_SYNC_START = 1390,
    parameter int H_SYNC_END   = 1430,
    parameter int V_ACTIVE     = 720,
    parameter int V_TOTAL      = 750,
    parameter int V_SYNC_START = 725,
    parameter int V_SYNC_END   = 730
) (
    input  logic               clk_pixel,
    input  logic               sys_rst_pixel,
    output pixel_pkg::timing_t timing_o
);

    // free running raster counters
    pixel_pkg::h_count_t h_cnt;
    pixel_pkg::v_count_t v_cnt;

    always_ff @(posedge clk_pixel) begin
        if (sys_rst_pixel) begin
            h_cnt    <= '0;
            v_cnt    <= '0;
            timing_o <= '0;
        end else begin
            // decode the current position into the registered word
            timing_o.h         <= h_cnt;
            timing_o.v         <= v_cnt;
            timing_o.active    <= (h_cnt < H_ACTIVE) && (v_cnt < V_ACTIVE);
            timing_o.h_sync    <= (h_cnt >= H_SYNC_START) && (h_cnt < H_SYNC_END);
            timing_o.v_sync    <= (v_cnt >= V_SYNC_START) && (v_cnt < V_SYNC_END);
            // one cycle at the start of the first blank line
            timing_o.new_frame <= (h_cnt == 0) && (v_cnt == V_ACTIVE);
            // wrap at end of line, then end of frame
            if (h_cnt == H_TOTAL - 1) begin
                h_cnt <= '0;
                if (v_cnt == V_TOTAL - 1) begin
                    v_cnt <= '0;
                end else begin
                    v_cnt <= v_cnt + 1'b1;
                end
            end else begin
                h_cnt <= h_cnt + 1'b1;
            end
        end
    end

endmodule

//--- rtl/pipe_delay.sv
`timescale 1ns/1ps

module pipe_delay #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 1
) (
    input  logic     clk_pixel,
    input  logic     sys_rst_pixel,
    input  payload_t data_i,
    output payload_t data_o
);

    // stage 0 takes the input, the last stage drives the output
    payload_t stages [DEPTH];

    always_ff @(posedge clk_pixel) begin
        if (sys_rst_pixel) begin
            stages <= '{default: '0};
        end else begin
            stages[0] <= data_i;
            for (int i = 1; i < DEPTH; i++) begin
                stages[i] <= stages[i-1];
            end
        end
    end

    assign data_o = stages[DEPTH-1];

endmodule

//--- rtl/color_convert.sv
`timescale 1ns/1ps

module color_convert (
    input  logic               clk_pixel,
    input  logic               sys_rst_pixel,
    input  logic [15:0]        pixel_i,
    input  pixel_pkg::timing_t timing_i,
    output pixel_pkg::rgb_t    rgb_o,
    output pixel_pkg::ycc_t    ycc_o,
    output pixel_pkg::timing_t timing_o
);

    // active flag lined up with the memory read data
    logic            act_q;
    pixel_pkg::rgb_t rgb_q;
    // products: 0..2 for y, 3..5 for cr, 6..8 for cb
    logic signed [17:0] prod_q [9];
    logic signed [19:0] sum_y;
    logic signed [19:0] sum_cr;
    logic signed [19:0] sum_cb;

    // unsigned channel times signed weight
    function automatic logic signed [17:0] scale(input logic [7:0] c, input int k);
        return 18'($signed({1'b0, c}) * k);
    endfunction

    always_ff @(posedge clk_pixel) begin
        if (sys_rst_pixel) begin
            act_q <= 1'b0;
        end else begin
            act_q <= timing_i.active;
        end
    end

    always_ff @(posedge clk_pixel) begin
        // stage 1, widen 5:6:5 by zero fill, blank outside the picture
        rgb_q.r <= act_q ? {pixel_i[15:11], 3'b000} : 8'h00;
        rgb_q.g <= act_q ? {pixel_i[10:5], 2'b00} : 8'h00;
        rgb_q.b <= act_q ? {pixel_i[4:0], 3'b000} : 8'h00;
        // stage 2, all nine products
        prod_q[0] <= scale(rgb_q.r, pixel_pkg::COEF_Y_R);
        prod_q[1] <= scale(rgb_q.g, pixel_pkg::COEF_Y_G);
        prod_q[2] <= scale(rgb_q.b, pixel_pkg::COEF_Y_B);
        prod_q[3] <= scale(rgb_q.r, pixel_pkg::COEF_CR_R);
        prod_q[4] <= scale(rgb_q.g, pixel_pkg::COEF_CR_G);
        prod_q[5] <= scale(rgb_q.b, pixel_pkg::COEF_CR_B);
        prod_q[6] <= scale(rgb_q.r, pixel_pkg::COEF_CB_R);
        prod_q[7] <= scale(rgb_q.g, pixel_pkg::COEF_CB_G);
        prod_q[8] <= scale(rgb_q.b, pixel_pkg::COEF_CB_B);
        // stage 3, bits 15:8 give floor(sum/256) modulo 256
        ycc_o.y  <= sum_y[15:8];
        ycc_o.cr <= sum_cr[15:8] + 8'd128;
        ycc_o.cb <= sum_cb[15:8] + 8'd128;
    end

    assign sum_y  = prod_q[0] + prod_q[1] + prod_q[2];
    assign sum_cr = prod_q[3] + prod_q[4] + prod_q[5];
    assign sum_cb = prod_q[6] + prod_q[7] + prod_q[8];

    // timing covers the memory cycle plus the three stages
    pipe_delay #(
        .payload_t (pixel_pkg::timing_t),
        .DEPTH     (pixel_pkg::CONVERT_LATENCY + 1)
    ) u_timing_dly (
        .clk_pixel     (clk_pixel),
        .sys_rst_pixel (sys_rst_pixel),
        .data_i        (timing_i),
        .data_o        (timing_o)
    );

    // rgb leaves stage 1 and waits for the ycc result
    pipe_delay #(
        .payload_t (pixel_pkg::rgb_t),
        .DEPTH     (pixel_pkg::CONVERT_LATENCY - 1)
    ) u_rgb_dly (
        .clk_pixel     (clk_pixel),
        .sys_rst_pixel (sys_rst_pixel),
        .data_i        (rgb_q),
        .data_o        (rgb_o)
    );

endmodule

//--- rtl/mask_stage.sv
`timescale 1ns/1ps

module mask_stage (
    input  logic                 clk_pixel,
    input  logic                 sys_rst_pixel,
    input  pixel_pkg::rgb_t      rgb_i,
    input  pixel_pkg::ycc_t      ycc_i,
    input  pixel_pkg::timing_t   timing_i,
    input  pixel_pkg::chan_sel_e chan_sel_i,
    input  logic [7:0]           lower_i,
    input  logic [7:0]           upper_i,
    output logic [7:0]           chan_o,
    output logic                 mask_o,
    output pixel_pkg::rgb_t      rgb_o,
    output logic [7:0]           ycc_y_o,
    output pixel_pkg::timing_t   timing_o
);

    logic [7:0] chan;

    // pick one of the six channels, zero for the unused codes
    always_comb begin
        case (chan_sel_i)
            pixel_pkg::CHAN_GREEN: chan = rgb_i.g;
            pixel_pkg::CHAN_RED:   chan = rgb_i.r;
            pixel_pkg::CHAN_BLUE:  chan = rgb_i.b;
            pixel_pkg::CHAN_Y:     chan = ycc_i.y;
            pixel_pkg::CHAN_CR:    chan = ycc_i.cr;
            pixel_pkg::CHAN_CB:    chan = ycc_i.cb;
            default:               chan = 8'h00;
        endcase
    end

    always_ff @(posedge clk_pixel) begin
        if (sys_rst_pixel) begin
            mask_o   <= 1'b0;
            timing_o <= '0;
        end else begin
            // both bounds inclusive
            mask_o   <= (chan >= lower_i) && (chan <= upper_i);
            timing_o <= timing_i;
        end
    end

    // pixel data rides along one cycle
    always_ff @(posedge clk_pixel) begin
        chan_o  <= chan;
        rgb_o   <= rgb_i;
        ycc_y_o <= ycc_i.y;
    end

endmodule

//--- rtl/centroid_unit.sv
`timescale 1ns/1ps

module centroid_unit (
    input  logic                clk_pixel,
    input  logic                sys_rst_pixel,
    input  logic                mask_i,
    input  pixel_pkg::timing_t  timing_i,
    output pixel_pkg::h_count_t com_x_o,
    output pixel_pkg::v_count_t com_y_o,
    output logic                com_valid_o
);

    // an average is below 2^QW, so QW quotient bits are enough
    localparam int QW = $bits(pixel_pkg::h_count_t);

    typedef enum logic [1:0] {
        DIV_IDLE,
        DIV_X,
        DIV_Y
    } div_state_e;

    div_state_e state_q;
    logic [31:0] acc_x;
    logic [31:0] acc_y;
    logic [20:0] acc_n;
    logic [3:0]  bit_q;
    // y sum and count held while x is divided
    logic [31:0] lat_y;
    logic [20:0] lat_n;
    // restoring divider
    logic [31:0]   rem_q;
    logic [31:0]   den_q;
    logic [QW-1:0] quo_q;
    logic          ge;
    logic [QW-1:0] quo_next;

    assign ge       = rem_q >= den_q;
    assign quo_next = {quo_q[QW-2:0], ge};

    always_ff @(posedge clk_pixel) begin
        if (sys_rst_pixel) begin
            state_q     <= DIV_IDLE;
            acc_x       <= '0;
            acc_y       <= '0;
            acc_n       <= '0;
            bit_q       <= '0;
            com_valid_o <= 1'b0;
        end else begin
            com_valid_o <= 1'b0;
            // frame sums, restarted at each frame boundary
            if (timing_i.new_frame) begin
                acc_x <= '0;
                acc_y <= '0;
                acc_n <= '0;
            end else if (mask_i && timing_i.active) begin
                acc_x <= acc_x + 32'(timing_i.h);
                acc_y <= acc_y + 32'(timing_i.v);
                acc_n <= acc_n + 1'b1;
            end
            case (state_q)
                DIV_IDLE: begin
                    // an empty mask never starts a division
                    if (timing_i.new_frame && acc_n != 0) begin
                        bit_q   <= 4'(QW - 1);
                        state_q <= DIV_X;
                    end
                end
                DIV_X: begin
                    bit_q <= bit_q - 1'b1;
                    if (bit_q == 0) begin
                        bit_q   <= 4'(QW - 1);
                        state_q <= DIV_Y;
                    end
                end
                default: begin
                    bit_q <= bit_q - 1'b1;
                    if (bit_q == 0) begin
                        com_valid_o <= 1'b1;
                        state_q     <= DIV_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk_pixel) begin
        if (state_q == DIV_IDLE) begin
            // load x first, keep y for the second pass
            lat_y <= acc_y;
            lat_n <= acc_n;
            rem_q <= acc_x;
            den_q <= 32'(acc_n) << (QW - 1);
            quo_q <= '0;
        end else begin
            // one quotient bit per cycle, msb first
            if (ge) begin
                rem_q <= rem_q - den_q;
            end
            den_q <= den_q >> 1;
            quo_q <= quo_next;
            if (bit_q == 0 && state_q == DIV_X) begin
                com_x_o <= quo_next;
                rem_q   <= lat_y;
                den_q   <= 32'(lat_n) << (QW - 1);
                quo_q   <= '0;
            end else if (bit_q == 0) begin
                com_y_o <= pixel_pkg::v_count_t'(quo_next);
            end
        end
    end

endmodule

//--- rtl/overlay_mux.sv
`timescale 1ns/1ps

module overlay_mux (
    input  logic                clk_pixel,
    input  logic                sys_rst_pixel,
    input  pixel_pkg::rgb_t     rgb_i,
    input  logic [7:0]          ycc_y_i,
    input  logic [7:0]          chan_i,
    input  logic                mask_i,
    input  pixel_pkg::timing_t  timing_i,
    input  pixel_pkg::h_count_t com_x_i,
    input  pixel_pkg::v_count_t com_y_i,
    input  logic                com_valid_i,
    input  pixel_pkg::bg_sel_e  bg_sel_i,
    input  pixel_pkg::tgt_sel_e tgt_sel_i,
    output pixel_pkg::rgb_t     rgb_o,
    output logic                h_sync_o,
    output logic                v_sync_o,
    output logic                active_o
);

    // crosshair position, moves only on a new result
    pixel_pkg::h_count_t cross_x;
    pixel_pkg::v_count_t cross_y;
    pixel_pkg::rgb_t     pix;

    always_comb begin
        case (bg_sel_i)
            pixel_pkg::BG_CAMERA: pix = rgb_i;
            pixel_pkg::BG_GRAY:   pix = {3{chan_i}};
            pixel_pkg::BG_MASK:   pix = mask_i ? 24'hFFFFFF : 24'h000000;
            default:              pix = mask_i ? 24'hFF00FF : {3{ycc_y_i}};
        endcase
        // white lines through the centroid, other targets draw nothing
        if (tgt_sel_i == pixel_pkg::TGT_CROSSHAIR &&
            (timing_i.h == cross_x || timing_i.v == cross_y)) begin
            pix = 24'hFFFFFF;
        end
        if (!timing_i.active) begin
            pix = '0;
        end
    end

    always_ff @(posedge clk_pixel) begin
        if (sys_rst_pixel) begin
            cross_x  <= '0;
            cross_y  <= '0;
            rgb_o    <= '0;
            h_sync_o <= 1'b0;
            v_sync_o <= 1'b0;
            active_o <= 1'b0;
        end else begin
            if (com_valid_i) begin
                cross_x <= com_x_i;
                cross_y <= com_y_i;
            end
            // pixel and syncs leave on the same edge
            rgb_o    <= pix;
            h_sync_o <= timing_i.h_sync;
            v_sync_o <= timing_i.v_sync;
            active_o <= timing_i.active;
        end
    end

endmodule

//--- rtl/tracker_top.sv
`timescale 1ns/1ps

module tracker_top #(
    parameter int H_ACTIVE     = 1280,
    parameter int H_TOTAL      = 1650,
    parameter int H_SYNC_START = 1390,
    parameter int H_SYNC_END   = 1430,
    parameter int V_ACTIVE     = 720,
    parameter int V_TOTAL      = 750,
    parameter int V_SYNC_START = 725,
    parameter int V_SYNC_END   = 730
) (
    input  logic                 clk_pixel,
    input  logic                 sys_rst_pixel,
    input  logic [15:0]          pixel_i,
    input  pixel_pkg::chan_sel_e chan_sel_i,
    input  logic [7:0]           lower_i,
    input  logic [7:0]           upper_i,
    input  pixel_pkg::bg_sel_e   bg_sel_i,
    input  pixel_pkg::tgt_sel_e  tgt_sel_i,
    output pixel_pkg::h_count_t  fetch_h_o,
    output pixel_pkg::v_count_t  fetch_v_o,
    output pixel_pkg::rgb_t      rgb_o,
    output logic                 h_sync_o,
    output logic                 v_sync_o,
    output logic                 active_o,
    output pixel_pkg::h_count_t  com_x_o,
    output pixel_pkg::v_count_t  com_y_o,
    output logic                 com_valid_o
);

    // raster position at t, converted pixel at t+4, mask at t+5
    pixel_pkg::timing_t vt_timing;
    pixel_pkg::timing_t cc_timing;
    pixel_pkg::timing_t ms_timing;
    pixel_pkg::rgb_t    cc_rgb;
    pixel_pkg::rgb_t    ms_rgb;
    pixel_pkg::ycc_t    cc_ycc;
    logic [7:0]         ms_chan;
    logic [7:0]         ms_y;
    logic               ms_mask;

    video_timing #(
        .H_ACTIVE     (H_ACTIVE),
        .H_TOTAL      (H_TOTAL),
        .H_SYNC_START (H_SYNC_START),
        .H_SYNC_END   (H_SYNC_END),
        .V_ACTIVE     (V_ACTIVE),
        .V_TOTAL      (V_TOTAL),
        .V_SYNC_START (V_SYNC_START),
        .V_SYNC_END   (V_SYNC_END)
    ) u_timing (
        .clk_pixel     (clk_pixel),
        .sys_rst_pixel (sys_rst_pixel),
        .timing_o      (vt_timing)
    );

    // read address to the frame buffer, data back one cycle later
    assign fetch_h_o = vt_timing.h;
    assign fetch_v_o = vt_timing.v;

    color_convert u_convert (
        .clk_pixel     (clk_pixel),
        .sys_rst_pixel (sys_rst_pixel),
        .pixel_i       (pixel_i),
        .timing_i      (vt_timing),
        .rgb_o         (cc_rgb),
        .ycc_o         (cc_ycc),
        .timing_o      (cc_timing)
    );

    mask_stage u_mask (
        .clk_pixel     (clk_pixel),
        .sys_rst_pixel (sys_rst_pixel),
        .rgb_i         (cc_rgb),
        .ycc_i         (cc_ycc),
        .timing_i      (cc_timing),
        .chan_sel_i    (chan_sel_i),
        .lower_i       (lower_i),
        .upper_i       (upper_i),
        .chan_o        (ms_chan),
        .mask_o        (ms_mask),
        .rgb_o         (ms_rgb),
        .ycc_y_o       (ms_y),
        .timing_o      (ms_timing)
    );

    centroid_unit u_centroid (
        .clk_pixel     (clk_pixel),
        .sys_rst_pixel (sys_rst_pixel),
        .mask_i        (ms_mask),
        .timing_i      (ms_timing),
        .com_x_o       (com_x_o),
        .com_y_o       (com_y_o),
        .com_valid_o   (com_valid_o)
    );

    overlay_mux u_overlay (
        .clk_pixel     (clk_pixel),
        .sys_rst_pixel (sys_rst_pixel),
        .rgb_i         (ms_rgb),
        .ycc_y_i       (ms_y),
        .chan_i        (ms_chan),
        .mask_i        (ms_mask),
        .timing_i      (ms_timing),
        .com_x_i       (com_x_o),
        .com_y_i       (com_y_o),
        .com_valid_i   (com_valid_o),
        .bg_sel_i      (bg_sel_i),
        .tgt_sel_i     (tgt_sel_i),
        .rgb_o         (rgb_o),
        .h_sync_o      (h_sync_o),
        .v_sync_o      (v_sync_o),
        .active_o      (active_o)
    );

endmodule

//--- sim/clock_gen.sv
`timescale 1ns/1ps

module clock_gen #(
    parameter real PERIOD_NS    = 8.0,
    parameter int  RESET_CYCLES = 8
) (
    output logic clk_pixel,
    output logic sys_rst_pixel
);

    // free running pixel clock
    initial begin
        clk_pixel = 1'b0;
        forever #(PERIOD_NS / 2.0) clk_pixel = ~clk_pixel;
    end

    // reset held high over the first edges, released on a rising edge
    initial begin
        sys_rst_pixel = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_pixel);
        sys_rst_pixel <= 1'b0;
    end

endmodule

//--- sim/tracker_props.sv
`timescale 1ns/1ps

module tracker_props #(
    parameter int H_ACTIVE = 1280
) (
    input logic                clk_pixel,
    input logic                sys_rst_pixel,
    input pixel_pkg::rgb_t     rgb_i,
    input logic                active_i,
    input pixel_pkg::h_count_t com_x_i,
    input logic                com_valid_i
);

    // result strobe lasts exactly one cycle
    valid_pulse_a: assert property (@(posedge clk_pixel) disable iff (sys_rst_pixel)
        com_valid_i |=> !com_valid_i)
        else $error("com_valid_o stayed high for a second cycle");

    // blanking carries black only
    blank_black_a: assert property (@(posedge clk_pixel) disable iff (sys_rst_pixel)
        !active_i |-> (rgb_i == '0))
        else $error("rgb_o is not zero while active_o is low");

    // an average column always lies inside the picture
    com_range_a: assert property (@(posedge clk_pixel) disable iff (sys_rst_pixel)
        com_valid_i |-> (com_x_i < H_ACTIVE))
        else $error("com_x_o outside the active width");

endmodule

// attached to every tracker_top instance
bind tracker_top tracker_props #(
    .H_ACTIVE (H_ACTIVE)
) u_props (
    .clk_pixel     (clk_pixel),
    .sys_rst_pixel (sys_rst_pixel),
    .rgb_i         (rgb_o),
    .active_i      (active_o),
    .com_x_i       (com_x_o),
    .com_valid_i   (com_valid_o)
);

//--- sim/tb_tracker.sv
`timescale 1ns/1ps

module tb_tracker;

    // small raster, 288 cycles per frame
    localparam int H_ACTIVE     = 16;
    localparam int H_TOTAL      = 24;
    localparam int H_SYNC_START = 18;
    localparam int H_SYNC_END   = 20;
    localparam int V_ACTIVE     = 8;
    localparam int V_TOTAL      = 12;
    localparam int V_SYNC_START = 9;
    localparam int V_SYNC_END   = 10;

    localparam int FRAME_CYCLES   = H_TOTAL * V_TOTAL;
    localparam int BLANK_CYCLES   = (V_TOTAL - V_ACTIVE) * H_TOTAL;
    localparam int LATENCY        = 6;
    localparam int NUM_ROWS       = 13;
    localparam int TIMEOUT_CYCLES = NUM_ROWS * FRAME_CYCLES + 100;
    localparam logic [31:0] SEED  = 32'd96678;

    // control settings for one frame
    typedef struct packed {
        logic [2:0] chan;
        logic [7:0] lower;
        logic [7:0] upper;
        logic [1:0] bg;
        logic [1:0] tgt;
    } row_t;

    // expected output for one pixel slot, chk clear while the pipe fills
    typedef struct packed {
        logic            chk;
        pixel_pkg::rgb_t rgb;
        logic            h_sync;
        logic            v_sync;
        logic            active;
    } out_t;

    localparam row_t ROWS [NUM_ROWS] = '{
        // chan    lower  upper  bg     tgt
        '{3'b000, 8'h00, 8'hFF, 2'b00, 2'b01},
        '{3'b001, 8'h40, 8'hBF, 2'b00, 2'b00},
        '{3'b000, 8'h20, 8'h9F, 2'b01, 2'b00},
        '{3'b010, 8'h80, 8'hFF, 2'b01, 2'b01},
        '{3'b100, 8'h30, 8'hA0, 2'b01, 2'b00},
        '{3'b101, 8'h70, 8'h90, 2'b01, 2'b01},
        '{3'b110, 8'h60, 8'h98, 2'b01, 2'b00},
        // invalid code reads 0, so this mask is empty
        '{3'b011, 8'h01, 8'hFF, 2'b01, 2'b01},
        '{3'b001, 8'h80, 8'h80, 2'b10, 2'b00},
        // partial mask, magenta on hits and y gray elsewhere
        '{3'b100, 8'h40, 8'hA0, 2'b11, 2'b01},
        '{3'b101, 8'h10, 8'h7F, 2'b10, 2'b01},
        '{3'b111, 8'h00, 8'h00, 2'b11, 2'b10},
        // lower above upper, nothing passes
        '{3'b010, 8'hF0, 8'h10, 2'b10, 2'b11}
    };

    logic                 clk_pixel;
    logic                 sys_rst_pixel;
    logic [15:0]          pixel_i = '0;
    pixel_pkg::chan_sel_e chan_sel_i;
    logic [7:0]           lower_i;
    logic [7:0]           upper_i;
    pixel_pkg::bg_sel_e   bg_sel_i;
    pixel_pkg::tgt_sel_e  tgt_sel_i;
    pixel_pkg::h_count_t  fetch_h_o;
    pixel_pkg::v_count_t  fetch_v_o;
    pixel_pkg::rgb_t      rgb_o;
    logic                 h_sync_o;
    logic                 v_sync_o;
    logic                 active_o;
    pixel_pkg::h_count_t  com_x_o;
    pixel_pkg::v_count_t  com_y_o;
    logic                 com_valid_o;

    // reference state, frame_cnt counts finished frames
    out_t                exp_pipe [LATENCY] = '{default: '0};
    logic                rst_prev = 1'b1;
    int                  frame_cnt = 0;
    int                  cycle_cnt = 0;
    int                  sum_x = 0;
    int                  sum_y = 0;
    int                  sum_n = 0;
    int                  exp_n = 0;
    int                  exp_x = 0;
    int                  exp_y = 0;
    pixel_pkg::h_count_t cross_x = '0;
    pixel_pkg::v_count_t cross_y = '0;
    // raster position the fetch address should show
    int                  pos_h = 0;
    int                  pos_v = 0;

    clock_gen u_clock (
        .clk_pixel     (clk_pixel),
        .sys_rst_pixel (sys_rst_pixel)
    );

    tracker_top #(
        .H_ACTIVE     (H_ACTIVE),
        .H_TOTAL      (H_TOTAL),
        .H_SYNC_START (H_SYNC_START),
        .H_SYNC_END   (H_SYNC_END),
        .V_ACTIVE     (V_ACTIVE),
        .V_TOTAL      (V_TOTAL),
        .V_SYNC_START (V_SYNC_START),
        .V_SYNC_END   (V_SYNC_END)
    ) uut (
        .clk_pixel     (clk_pixel),
        .sys_rst_pixel (sys_rst_pixel),
        .pixel_i       (pixel_i),
        .chan_sel_i    (chan_sel_i),
        .lower_i       (lower_i),
        .upper_i       (upper_i),
        .bg_sel_i      (bg_sel_i),
        .tgt_sel_i     (tgt_sel_i),
        .fetch_h_o     (fetch_h_o),
        .fetch_v_o     (fetch_v_o),
        .rgb_o         (rgb_o),
        .h_sync_o      (h_sync_o),
        .v_sync_o      (v_sync_o),
        .active_o      (active_o),
        .com_x_o       (com_x_o),
        .com_y_o       (com_y_o),
        .com_valid_o   (com_valid_o)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // frame buffer contents, a hash of frame index and address
    function automatic logic [15:0] image_word(input int frame, input logic [10:0] h,
                                               input logic [9:0] v);
        logic [31:0] s;
        s = lcg_next(SEED + 32'(frame));
        s = lcg_next(s ^ {11'd0, v, h});
        s = lcg_next(s);
        return s[31:16];
    endfunction

    // zero fill of the low bits
    function automatic pixel_pkg::rgb_t unpack_565(input logic [15:0] w);
        pixel_pkg::rgb_t c;
        c.r = {w[15:11], 3'b000};
        c.g = {w[10:5], 2'b00};
        c.b = {w[4:0], 3'b000};
        return c;
    endfunction

    // weighted sum over 256, floored, offset, modulo 256
    function automatic logic [7:0] weigh(input pixel_pkg::rgb_t c, input int kr, input int kg,
                                         input int kb, input int offset);
        int s;
        s = kr * int'(c.r) + kg * int'(c.g) + kb * int'(c.b);
        return 8'((s >>> 8) + offset);
    endfunction

    function automatic logic [7:0] pick_channel(input logic [2:0] code,
                                                input pixel_pkg::rgb_t c);
        case (code)
            3'b000:  return c.g;
            3'b001:  return c.r;
            3'b010:  return c.b;
            3'b100:  return weigh(c, 77, 150, 29, 0);
            3'b101:  return weigh(c, 128, -107, -21, 128);
            3'b110:  return weigh(c, -43, -85, 128, 128);
            default: return 8'h00;
        endcase
    endfunction

    task automatic abort_run();
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH time=%0t %s got=%0h expected=%0h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic apply_row(input row_t row);
        chan_sel_i <= pixel_pkg::chan_sel_e'(row.chan);
        lower_i    <= row.lower;
        upper_i    <= row.upper;
        bg_sel_i   <= pixel_pkg::bg_sel_e'(row.bg);
        tgt_sel_i  <= pixel_pkg::tgt_sel_e'(row.tgt);
    endtask

    // one pulse expected within the blank, none for an empty mask
    task automatic check_centroid(input int row);
        bit seen;
        seen = 1'b0;
        for (int c = 0; c < BLANK_CYCLES && !seen; c++) begin
            @(posedge clk_pixel);
            if (com_valid_o) begin
                seen = 1'b1;
                if (exp_n == 0) begin
                    $display("%0t: centroid pulse after frame %0d with empty mask", $time, row);
                    abort_run();
                end
                check_value("com_x_o", 32'(com_x_o), 32'(exp_x));
                check_value("com_y_o", 32'(com_y_o), 32'(exp_y));
            end
        end
        if (!seen && exp_n != 0) begin
            $display("%0t: no centroid pulse in the blank after frame %0d", $time, row);
            abort_run();
        end
    endtask

    // memory model and reference model, one fetch per edge
    always @(posedge clk_pixel) begin
        logic [15:0]     word;
        pixel_pkg::rgb_t cam;
        logic [7:0]      chan;
        logic            hit;
        out_t            exp;
        // output registered last cycle matches the fetch read six edges ago
        if (exp_pipe[LATENCY-1].chk) begin
            check_value("rgb_o", 32'(rgb_o), 32'(exp_pipe[LATENCY-1].rgb));
            check_value("h_sync_o", 32'(h_sync_o), 32'(exp_pipe[LATENCY-1].h_sync));
            check_value("v_sync_o", 32'(v_sync_o), 32'(exp_pipe[LATENCY-1].v_sync));
            check_value("active_o", 32'(active_o), 32'(exp_pipe[LATENCY-1].active));
        end
        word = image_word(frame_cnt, fetch_h_o, fetch_v_o);
        pixel_i <= word;
        exp = '0;
        exp.chk = 1'b1;
        // address registered under reset is not a real fetch, output stays 0
        if (!rst_prev) begin
            // the fetch address walks the raster from (0,0)
            check_value("fetch_h_o", 32'(fetch_h_o), 32'(pos_h));
            check_value("fetch_v_o", 32'(fetch_v_o), 32'(pos_v));
            exp.active = (pos_h < H_ACTIVE) && (pos_v < V_ACTIVE);
            exp.h_sync = (pos_h >= H_SYNC_START) && (pos_h < H_SYNC_END);
            exp.v_sync = (pos_v >= V_SYNC_START) && (pos_v < V_SYNC_END);
            cam = exp.active ? unpack_565(word) : '0;
            chan = pick_channel(chan_sel_i, cam);
            hit = (chan >= lower_i) && (chan <= upper_i);
            case (bg_sel_i)
                2'b00:   exp.rgb = cam;
                2'b01:   exp.rgb = {3{chan}};
                2'b10:   exp.rgb = hit ? 24'hFFFFFF : 24'h000000;
                default: exp.rgb = hit ? 24'hFF00FF : {3{weigh(cam, 77, 150, 29, 0)}};
            endcase
            if (tgt_sel_i == 2'b01 && (pos_h == cross_x || pos_v == cross_y)) begin
                exp.rgb = 24'hFFFFFF;
            end
            if (!exp.active) begin
                exp.rgb = '0;
            end
            if (exp.active && hit) begin
                sum_x += pos_h;
                sum_y += pos_v;
                sum_n += 1;
            end
            // first blank line, the frame's sums are final
            if (pos_h == 0 && pos_v == V_ACTIVE) begin
                exp_n <= sum_n;
                exp_x <= (sum_n != 0) ? sum_x / sum_n : 0;
                exp_y <= (sum_n != 0) ? sum_y / sum_n : 0;
                if (sum_n != 0) begin
                    cross_x = pixel_pkg::h_count_t'(sum_x / sum_n);
                    cross_y = pixel_pkg::v_count_t'(sum_y / sum_n);
                end
                sum_x = 0;
                sum_y = 0;
                sum_n = 0;
                frame_cnt <= frame_cnt + 1;
            end
            // next raster position, line wrap then frame wrap
            if (pos_h == H_TOTAL - 1) begin
                pos_h = 0;
                pos_v = (pos_v == V_TOTAL - 1) ? 0 : pos_v + 1;
            end else begin
                pos_h = pos_h + 1;
            end
        end
        for (int i = LATENCY - 1; i > 0; i--) begin
            exp_pipe[i] = exp_pipe[i-1];
        end
        exp_pipe[0] = exp;
        rst_prev = sys_rst_pixel;
    end

    // run limit from the number of frames in the table
    always @(posedge clk_pixel) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("%0t: timeout, run did not finish in %0d cycles", $time, TIMEOUT_CYCLES);
            abort_run();
        end
    end

    initial begin
        apply_row(ROWS[0]);
        for (int r = 0; r < NUM_ROWS; r++) begin
            while (frame_cnt <= r) begin
                @(posedge clk_pixel);
            end
            // next settings take effect at the start of vertical blank
            if (r + 1 < NUM_ROWS) begin
                apply_row(ROWS[r+1]);
            end
            check_centroid(r);
        end
        $display("Test completed successfully");
        $finish;
    end

endmodule

//--- project.f
rtl/pixel_pkg.sv
rtl/video_timing.sv
rtl/pipe_delay.sv
rtl/color_convert.sv
rtl/mask_stage.sv
rtl/centroid_unit.sv
rtl/overlay_mux.sv
rtl/tracker_top.sv
sim/clock_gen.sv
sim/tracker_props.sv
sim/tb_tracker.sv

//--- run_sim.sh
#!/bin/sh
# build and run the tracker testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal \
        -f project.f --top-module tb_tracker -o sim_tracker; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_tracker 2>&1)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "Test completed successfully"; then
    exit 0
fi

echo "pass message not found in simulation output"
exit 1
